// ==== hw/stbuf_params.svh ====
// Sizing macros for the store buffer
// Entry count, physical address width, buffer line width
// and L1D write port width
`ifndef STBUF_PARAMS_SVH
`define STBUF_PARAMS_SVH

// --------------------
// Buffer geometry
// --------------------

// Number of buffer entries
`define STBUF_ENTRIES 4

// Physical address width
`define STBUF_PADDR_W 32

// Bits held per entry, one buffer line
`define STBUF_WIDTH 64

// --------------------
// Cache side
// --------------------

// L1D write port width, a multiple of the line width
`define STBUF_DC_DATA_W 128

`endif

// ==== hw/stbuf_pkg.sv ====
// Shared types for the store buffer
// Address, entry data and strobe types, cache port types,
// entry vectors, store response and entry state enums
package stbuf_pkg;

`include "stbuf_params.svh"

  // Address bit positions
  localparam int LINE_LSB = $clog2(`STBUF_WIDTH / 8);
  localparam int DC_LSB   = $clog2(`STBUF_DC_DATA_W / 8);

  // --------------------
  // Data types
  // --------------------
  typedef logic [`STBUF_PADDR_W-1:0]       paddr_t;
  typedef logic [`STBUF_WIDTH-1:0]         stbuf_data_t;
  typedef logic [`STBUF_WIDTH/8-1:0]       stbuf_strb_t;
  typedef logic [`STBUF_DC_DATA_W-1:0]     dc_data_t;
  typedef logic [`STBUF_DC_DATA_W/8-1:0]   dc_be_t;

  // One bit per entry
  typedef logic [`STBUF_ENTRIES-1:0]       entry_oh_t;

  // Answer to a committed store
  typedef enum logic [1:0] {
    STBUF_ALLOC = 2'd0,
    STBUF_MERGE = 2'd1,
    STBUF_FULL  = 2'd2
  } stbuf_resp_t;

  // Entry drain state
  typedef enum logic [1:0] {
    ST_IDLE      = 2'd0,
    ST_READY     = 2'd1,
    ST_WAIT_RESP = 2'd2
  } stbuf_state_t;

endpackage

// ==== hw/stbuf_alloc.sv ====
// Store allocation for the store buffer
// Line compare against the entries, merge/refuse/allocate
// decision and the rotating input pointer
`include "stbuf_params.svh"

module stbuf_alloc (
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  logic                   i_st_valid,
  input  stbuf_pkg::paddr_t      i_st_paddr,
  input  stbuf_pkg::entry_oh_t   i_valid,
  input  stbuf_pkg::entry_oh_t   i_mergeable,
  input  stbuf_pkg::entry_oh_t   i_wait,
  input  stbuf_pkg::paddr_t      i_paddr [`STBUF_ENTRIES],
  output stbuf_pkg::entry_oh_t   o_load,
  output stbuf_pkg::entry_oh_t   o_merge,
  output stbuf_pkg::stbuf_resp_t o_st_resp
);

  import stbuf_pkg::*;

  entry_oh_t w_match;
  entry_oh_t w_merge;
  entry_oh_t w_refuse;
  entry_oh_t r_in_ptr;
  logic      w_full;
  logic      w_alloc;

  // Same buffer line as the incoming store
  always_comb begin
    for (int e = 0; e < `STBUF_ENTRIES; e++) begin
      w_match[e] = i_valid[e] &
                   (i_paddr[e][`STBUF_PADDR_W-1:LINE_LSB] ==
                    i_st_paddr[`STBUF_PADDR_W-1:LINE_LSB]);
    end
  end

  assign w_merge  = w_match & i_mergeable & {`STBUF_ENTRIES{i_st_valid}};
  assign w_refuse = w_match & i_wait & {`STBUF_ENTRIES{i_st_valid}};
  assign w_full   = &i_valid;
  assign w_alloc  = i_st_valid & ~|w_merge & ~|w_refuse & ~w_full;

  assign o_merge = w_merge;
  assign o_load  = r_in_ptr & {`STBUF_ENTRIES{w_alloc}};

  always_comb begin
    if (|w_merge) begin
      o_st_resp = STBUF_MERGE;
    end else if (|w_refuse || w_full) begin
      // Line busy at the cache or no free entry
      o_st_resp = STBUF_FULL;
    end else begin
      o_st_resp = STBUF_ALLOC;
    end
  end

  // --------------------
  // Input pointer
  // --------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_in_ptr <= entry_oh_t'(1);
    end else if (w_alloc) begin
      r_in_ptr <= {r_in_ptr[`STBUF_ENTRIES-2:0], r_in_ptr[`STBUF_ENTRIES-1]};
    end
  end

endmodule

// ==== hw/stbuf_entry.sv ====
// One store buffer entry
// Line address, byte strobes and data with byte merge,
// plus the drain state machine toward the L1D write port
module stbuf_entry (
  input  logic                   i_clk,
  input  logic                   i_reset_n,

  // Fill from the store input
  input  logic                   i_load,
  input  logic                   i_merge,
  input  stbuf_pkg::paddr_t      i_st_paddr,
  input  stbuf_pkg::stbuf_strb_t i_st_strb,
  input  stbuf_pkg::stbuf_data_t i_st_data,

  // Drain control
  input  logic                   i_wr_issue,
  input  logic                   i_wr_done,
  input  logic                   i_wr_retry,

  output logic                   o_valid,
  output logic                   o_wr_req,
  output logic                   o_mergeable,
  output stbuf_pkg::paddr_t      o_paddr,
  output stbuf_pkg::stbuf_strb_t o_strb,
  output stbuf_pkg::stbuf_data_t o_data
);

  import stbuf_pkg::*;

  stbuf_state_t r_state;
  paddr_t       r_paddr;
  stbuf_strb_t  r_strb;
  stbuf_data_t  r_data;
  stbuf_data_t  w_merge_data;

  // --------------------
  // Drain FSM
  // --------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= ST_IDLE;
    end else begin
      case (r_state)
        ST_IDLE: begin
          if (i_load) begin
            r_state <= ST_READY;
          end
        end
        ST_READY: begin
          if (i_wr_issue) begin
            r_state <= ST_WAIT_RESP;
          end
        end
        ST_WAIT_RESP: begin
          if (i_wr_done) begin
            r_state <= ST_IDLE;
          end else if (i_wr_retry) begin
            // Conflict at the cache, try again
            r_state <= ST_READY;
          end
        end
        default: begin
          r_state <= ST_IDLE;
        end
      endcase
    end
  end

  // New bytes win where their strobe is set
  always_comb begin
    w_merge_data = r_data;
    for (int b = 0; b < $bits(stbuf_strb_t); b++) begin
      if (i_st_strb[b]) begin
        w_merge_data[b*8 +: 8] = i_st_data[b*8 +: 8];
      end
    end
  end

  // --------------------
  // Payload
  // --------------------
  always_ff @(posedge i_clk) begin
    if (i_load) begin
      r_paddr <= i_st_paddr;
      r_strb  <= i_st_strb;
      r_data  <= i_st_data;
    end else if (i_merge) begin
      r_strb  <= r_strb | i_st_strb;
      r_data  <= w_merge_data;
    end
  end

  assign o_valid     = (r_state != ST_IDLE);
  assign o_wr_req    = (r_state == ST_READY);
  assign o_mergeable = (r_state == ST_READY) & ~i_wr_issue;
  assign o_paddr     = r_paddr;
  assign o_strb      = r_strb;
  assign o_data      = r_data;

endmodule

// ==== hw/stbuf_drain.sv ====
// Drain of the store buffer to the L1D write port
// Oldest-entry select, write formatting, one write in flight
// and conflict handling on the one-cycle response
`include "stbuf_params.svh"

module stbuf_drain (
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  stbuf_pkg::entry_oh_t   i_wr_req,
  input  stbuf_pkg::paddr_t      i_paddr [`STBUF_ENTRIES],
  input  stbuf_pkg::stbuf_strb_t i_strb  [`STBUF_ENTRIES],
  input  stbuf_pkg::stbuf_data_t i_data  [`STBUF_ENTRIES],
  input  logic                   i_l1d_wr_conflict,
  output stbuf_pkg::entry_oh_t   o_wr_issue,
  output stbuf_pkg::entry_oh_t   o_wr_done,
  output stbuf_pkg::entry_oh_t   o_wr_retry,
  output logic                   o_l1d_wr_valid,
  output stbuf_pkg::paddr_t      o_l1d_wr_paddr,
  output stbuf_pkg::dc_data_t    o_l1d_wr_data,
  output stbuf_pkg::dc_be_t      o_l1d_wr_be
);

  import stbuf_pkg::*;

  // Entry lines per cache port word
  localparam int DC_MULT = `STBUF_DC_DATA_W / `STBUF_WIDTH;
  localparam int STRB_W  = `STBUF_WIDTH / 8;

  entry_oh_t   r_out_ptr;
  entry_oh_t   r_inflight_oh;
  logic        r_inflight;
  logic        w_issue;
  logic        w_resp_ok;
  paddr_t      w_sel_paddr;
  stbuf_strb_t w_sel_strb;
  stbuf_data_t w_sel_data;

  // Oldest entry sits under the output pointer
  always_comb begin
    w_sel_paddr = '0;
    w_sel_strb  = '0;
    w_sel_data  = '0;
    for (int e = 0; e < `STBUF_ENTRIES; e++) begin
      if (r_out_ptr[e]) begin
        w_sel_paddr = w_sel_paddr | i_paddr[e];
        w_sel_strb  = w_sel_strb | i_strb[e];
        w_sel_data  = w_sel_data | i_data[e];
      end
    end
  end

  assign w_issue   = |(r_out_ptr & i_wr_req) & ~r_inflight;
  assign w_resp_ok = r_inflight & ~i_l1d_wr_conflict;

  assign o_wr_issue = r_out_ptr & {`STBUF_ENTRIES{w_issue}};
  assign o_wr_done  = r_inflight_oh & {`STBUF_ENTRIES{w_resp_ok}};
  assign o_wr_retry = r_inflight_oh & {`STBUF_ENTRIES{r_inflight & i_l1d_wr_conflict}};

  // --------------------
  // Write formatting
  // --------------------
  assign o_l1d_wr_valid = w_issue;
  assign o_l1d_wr_paddr = {w_sel_paddr[`STBUF_PADDR_W-1:DC_LSB], {DC_LSB{1'b0}}};
  assign o_l1d_wr_data  = {DC_MULT{w_sel_data}};

  if (DC_MULT == 1) begin : g_be_direct
    assign o_l1d_wr_be = w_sel_strb;
  end else begin : g_be_slot
    logic [DC_LSB-LINE_LSB-1:0] w_slot;

    // Line position inside the port word
    assign w_slot      = w_sel_paddr[DC_LSB-1:LINE_LSB];
    assign o_l1d_wr_be = dc_be_t'(w_sel_strb) << (w_slot * STRB_W);
  end

  // --------------------
  // In-flight tracking
  // --------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_out_ptr     <= entry_oh_t'(1);
      r_inflight    <= 1'b0;
      r_inflight_oh <= '0;
    end else begin
      r_inflight    <= w_issue;
      r_inflight_oh <= o_wr_issue;
      if (w_resp_ok) begin
        r_out_ptr <= {r_out_ptr[`STBUF_ENTRIES-2:0], r_out_ptr[`STBUF_ENTRIES-1]};
      end
    end
  end

endmodule

// ==== hw/stbuf_fwd.sv ====
// Load forwarding from the store buffer
// Line match of one load address against the valid entries
// and selection of the matching entry's strobes and data
`include "stbuf_params.svh"

module stbuf_fwd (
  input  logic                   i_fwd_valid,
  input  stbuf_pkg::paddr_t      i_fwd_paddr,
  input  stbuf_pkg::entry_oh_t   i_valid,
  input  stbuf_pkg::paddr_t      i_paddr [`STBUF_ENTRIES],
  input  stbuf_pkg::stbuf_strb_t i_strb  [`STBUF_ENTRIES],
  input  stbuf_pkg::stbuf_data_t i_data  [`STBUF_ENTRIES],
  output logic                   o_fwd_hit,
  output stbuf_pkg::stbuf_strb_t o_fwd_be,
  output stbuf_pkg::stbuf_data_t o_fwd_data
);

  import stbuf_pkg::*;

  entry_oh_t w_hit;

  // At most one valid entry per line, so OR-select is safe
  always_comb begin
    o_fwd_be   = '0;
    o_fwd_data = '0;
    for (int e = 0; e < `STBUF_ENTRIES; e++) begin
      w_hit[e] = i_fwd_valid & i_valid[e] &
                 (i_paddr[e][`STBUF_PADDR_W-1:LINE_LSB] ==
                  i_fwd_paddr[`STBUF_PADDR_W-1:LINE_LSB]);
      if (w_hit[e]) begin
        o_fwd_be   = o_fwd_be | i_strb[e];
        o_fwd_data = o_fwd_data | i_data[e];
      end
    end
  end

  assign o_fwd_hit = |w_hit;

endmodule

// ==== hw/stbuf_top.sv ====
// Store buffer top level
// Allocation logic, entry array, drain to the L1D write port
// and load forwarding
`include "stbuf_params.svh"

module stbuf_top (
  input  logic                     i_clk,
  input  logic                     i_reset_n,

  // Committed store
  input  logic                     i_st_valid,
  input  stbuf_pkg::paddr_t        i_st_paddr,
  input  stbuf_pkg::stbuf_strb_t   i_st_strb,
  input  stbuf_pkg::stbuf_data_t   i_st_data,
  output stbuf_pkg::stbuf_resp_t   o_st_resp,

  // L1D write port
  output logic                     o_l1d_wr_valid,
  output stbuf_pkg::paddr_t        o_l1d_wr_paddr,
  output stbuf_pkg::dc_data_t      o_l1d_wr_data,
  output stbuf_pkg::dc_be_t        o_l1d_wr_be,
  input  logic                     i_l1d_wr_conflict,

  // Load forwarding
  input  logic                     i_fwd_valid,
  input  stbuf_pkg::paddr_t        i_fwd_paddr,
  output logic                     o_fwd_hit,
  output stbuf_pkg::stbuf_strb_t   o_fwd_be,
  output stbuf_pkg::stbuf_data_t   o_fwd_data,

  output logic                     o_empty
);

  import stbuf_pkg::*;

  entry_oh_t   w_load;
  entry_oh_t   w_merge;
  entry_oh_t   w_wr_issue;
  entry_oh_t   w_wr_done;
  entry_oh_t   w_wr_retry;
  entry_oh_t   w_valid;
  entry_oh_t   w_wr_req;
  entry_oh_t   w_mergeable;
  entry_oh_t   w_wait;
  paddr_t      w_paddr [`STBUF_ENTRIES];
  stbuf_strb_t w_strb  [`STBUF_ENTRIES];
  stbuf_data_t w_data  [`STBUF_ENTRIES];

  // Valid but locked against merging
  assign w_wait  = w_valid & ~w_mergeable;
  assign o_empty = ~|w_valid;

  // --------------------
  // Input side
  // --------------------
  stbuf_alloc u_alloc (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_st_valid  (i_st_valid),
    .i_st_paddr  (i_st_paddr),
    .i_valid     (w_valid),
    .i_mergeable (w_mergeable),
    .i_wait      (w_wait),
    .i_paddr     (w_paddr),
    .o_load      (w_load),
    .o_merge     (w_merge),
    .o_st_resp   (o_st_resp)
  );

  // --------------------
  // Entry array
  // --------------------
  for (genvar e = 0; e < `STBUF_ENTRIES; e++) begin : g_entry
    stbuf_entry u_entry (
      .i_clk       (i_clk),
      .i_reset_n   (i_reset_n),
      .i_load      (w_load[e]),
      .i_merge     (w_merge[e]),
      .i_st_paddr  (i_st_paddr),
      .i_st_strb   (i_st_strb),
      .i_st_data   (i_st_data),
      .i_wr_issue  (w_wr_issue[e]),
      .i_wr_done   (w_wr_done[e]),
      .i_wr_retry  (w_wr_retry[e]),
      .o_valid     (w_valid[e]),
      .o_wr_req    (w_wr_req[e]),
      .o_mergeable (w_mergeable[e]),
      .o_paddr     (w_paddr[e]),
      .o_strb      (w_strb[e]),
      .o_data      (w_data[e])
    );
  end

  // --------------------
  // Output side
  // --------------------
  stbuf_drain u_drain (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_wr_req          (w_wr_req),
    .i_paddr           (w_paddr),
    .i_strb            (w_strb),
    .i_data            (w_data),
    .i_l1d_wr_conflict (i_l1d_wr_conflict),
    .o_wr_issue        (w_wr_issue),
    .o_wr_done         (w_wr_done),
    .o_wr_retry        (w_wr_retry),
    .o_l1d_wr_valid    (o_l1d_wr_valid),
    .o_l1d_wr_paddr    (o_l1d_wr_paddr),
    .o_l1d_wr_data     (o_l1d_wr_data),
    .o_l1d_wr_be       (o_l1d_wr_be)
  );

  stbuf_fwd u_fwd (
    .i_fwd_valid (i_fwd_valid),
    .i_fwd_paddr (i_fwd_paddr),
    .i_valid     (w_valid),
    .i_paddr     (w_paddr),
    .i_strb      (w_strb),
    .i_data      (w_data),
    .o_fwd_hit   (o_fwd_hit),
    .o_fwd_be    (o_fwd_be),
    .o_fwd_data  (o_fwd_data)
  );

endmodule

// ==== bench/stbuf_tb.sv ====
// Testbench for the store buffer
// Random stores, load lookups and L1D conflicts from a fixed seed,
// a queue model of the entries, and a byte memory compare after the drain
`include "stbuf_params.svh"

module stbuf_tb;

  import stbuf_pkg::*;

  localparam int     NUM_LINES   = 6;
  localparam int     NUM_BYTES   = NUM_LINES * 8;
  localparam int     STIM_CYCLES = 600;
  localparam int     DRAIN_LIMIT = 200;
  localparam paddr_t BASE_ADDR   = 32'h0004_0000;

  logic        i_clk;
  logic        i_reset_n;
  logic        i_st_valid;
  paddr_t      i_st_paddr;
  stbuf_strb_t i_st_strb;
  stbuf_data_t i_st_data;
  stbuf_resp_t o_st_resp;
  logic        o_l1d_wr_valid;
  paddr_t      o_l1d_wr_paddr;
  dc_data_t    o_l1d_wr_data;
  dc_be_t      o_l1d_wr_be;
  logic        i_l1d_wr_conflict;
  logic        i_fwd_valid;
  paddr_t      i_fwd_paddr;
  logic        o_fwd_hit;
  stbuf_strb_t o_fwd_be;
  stbuf_data_t o_fwd_data;
  logic        o_empty;

  // Model entries, oldest first
  logic [28:0] m_line [$];
  stbuf_strb_t m_strb [$];
  stbuf_data_t m_data [$];
  bit          m_wait [$];
  bit          m_inflight;
  bit          conflict_next;

  // Write seen on its issue cycle
  paddr_t      pend_paddr;
  dc_data_t    pend_data;
  dc_be_t      pend_be;

  // Bytes from accepted stores and bytes written to the cache
  logic [7:0]  st_mem [NUM_BYTES];
  bit          st_set [NUM_BYTES];
  logic [7:0]  wr_mem [NUM_BYTES];
  bit          wr_set [NUM_BYTES];

  int n_errors;
  int n_alloc;
  int n_merge;
  int n_full;
  int n_writes;
  int n_conflicts;

  stbuf_top dut_i (.*);

  always #20 i_clk = ~i_clk;

  task automatic report_mismatch(input string name, input logic [127:0] exp,
                                 input logic [127:0] act);
    $display("[ERROR] %s expected %0h actual %0h", name, exp, act);
    n_errors++;
  endtask

  // --------------------
  // Stimulus
  // --------------------
  task automatic drive_inputs(input bit stim);
    i_st_valid        <= stim && ($urandom % 10 < 7);
    i_st_paddr        <= BASE_ADDR + paddr_t'(($urandom % NUM_LINES) * 8 + $urandom % 8);
    i_st_strb         <= stbuf_strb_t'($urandom % 255 + 1);
    i_st_data         <= {$urandom, $urandom};
    i_fwd_valid       <= stim && ($urandom % 2 == 0);
    // One line more than the stores use, so misses happen
    i_fwd_paddr       <= BASE_ADDR + paddr_t'(($urandom % (NUM_LINES + 1)) * 8);
    i_l1d_wr_conflict <= conflict_next;
  endtask

  // --------------------
  // Checks and model update, run at the falling edge
  // --------------------
  task automatic check_cycle();
    int          idx;
    int          fidx;
    int          ofs;
    bit          issue_now;
    stbuf_resp_t exp_resp;
    dc_be_t      exp_be;
    stbuf_data_t tmp;
    idx  = -1;
    fidx = -1;
    for (int i = 0; i < m_line.size(); i++) begin
      if (m_line[i] == i_st_paddr[31:3]) idx = i;
      if (i_fwd_valid && m_line[i] == i_fwd_paddr[31:3]) fidx = i;
    end
    issue_now = !m_inflight && m_line.size() > 0 && !m_wait[0];

    // Merge only into a ready entry that is not issued this cycle
    if (idx >= 0 && !m_wait[idx] && !(issue_now && idx == 0)) begin
      exp_resp = STBUF_MERGE;
    end else if (idx >= 0 || m_line.size() == `STBUF_ENTRIES) begin
      exp_resp = STBUF_FULL;
    end else begin
      exp_resp = STBUF_ALLOC;
    end
    if (i_st_valid && o_st_resp !== exp_resp) begin
      report_mismatch("store_resp", 128'(exp_resp), 128'(o_st_resp));
    end

    if (o_l1d_wr_valid !== issue_now) begin
      report_mismatch("wr_valid", 128'(issue_now), 128'(o_l1d_wr_valid));
    end else if (issue_now) begin
      exp_be = dc_be_t'(m_strb[0]) << (m_line[0][0] ? 8 : 0);
      if (o_l1d_wr_paddr !== {m_line[0][28:1], 4'b0000}) begin
        report_mismatch("wr_paddr", 128'({m_line[0][28:1], 4'b0000}), 128'(o_l1d_wr_paddr));
      end
      if (o_l1d_wr_data !== {m_data[0], m_data[0]}) begin
        report_mismatch("wr_data", {m_data[0], m_data[0]}, o_l1d_wr_data);
      end
      if (o_l1d_wr_be !== exp_be) begin
        report_mismatch("wr_be", 128'(exp_be), 128'(o_l1d_wr_be));
      end
      n_writes++;
    end
    pend_paddr = o_l1d_wr_paddr;
    pend_data  = o_l1d_wr_data;
    pend_be    = o_l1d_wr_be;
    // Cache answer for the next cycle
    conflict_next = (o_l1d_wr_valid === 1'b1) && ($urandom % 4 == 0);

    if (o_empty !== (m_line.size() == 0)) begin
      report_mismatch("empty", 128'(m_line.size() == 0), 128'(o_empty));
    end
    if (o_fwd_hit !== (fidx >= 0)) begin
      report_mismatch("fwd_hit", 128'(fidx >= 0), 128'(o_fwd_hit));
    end else if (fidx >= 0) begin
      if (o_fwd_be !== m_strb[fidx]) begin
        report_mismatch("fwd_be", 128'(m_strb[fidx]), 128'(o_fwd_be));
      end
      if (o_fwd_data !== m_data[fidx]) begin
        report_mismatch("fwd_data", 128'(m_data[fidx]), 128'(o_fwd_data));
      end
    end

    // Store takes effect at the next edge
    if (i_st_valid && exp_resp == STBUF_FULL) n_full++;
    if (i_st_valid && exp_resp != STBUF_FULL) begin
      ofs = int'(i_st_paddr - BASE_ADDR) & ~7;
      tmp = (exp_resp == STBUF_MERGE) ? m_data[idx] : i_st_data;
      for (int b = 0; b < 8; b++) begin
        if (i_st_strb[b]) begin
          st_mem[ofs + b] = i_st_data[b*8 +: 8];
          st_set[ofs + b] = 1'b1;
          tmp[b*8 +: 8]   = i_st_data[b*8 +: 8];
        end
      end
      if (exp_resp == STBUF_MERGE) begin
        m_data[idx] = tmp;
        m_strb[idx] = m_strb[idx] | i_st_strb;
        n_merge++;
      end else begin
        m_line.push_back(i_st_paddr[31:3]);
        m_strb.push_back(i_st_strb);
        m_data.push_back(i_st_data);
        m_wait.push_back(1'b0);
        n_alloc++;
      end
    end

    if (m_inflight && i_l1d_wr_conflict) begin
      m_wait[0] = 1'b0;
      n_conflicts++;
    end else if (m_inflight) begin
      void'(m_line.pop_front());
      void'(m_strb.pop_front());
      void'(m_data.pop_front());
      void'(m_wait.pop_front());
    end
    m_inflight = issue_now;
    if (issue_now) m_wait[0] = 1'b1;
  endtask

  // Successful cache writes land in the byte memory at the response edge
  task automatic apply_write();
    int ofs;
    for (int p = 0; p < 16; p++) begin
      ofs = int'(pend_paddr - BASE_ADDR) + p;
      if (pend_be[p] && (ofs < 0 || ofs >= NUM_BYTES)) begin
        $display("Cache write at address %h falls outside the stored lines", pend_paddr);
        n_errors++;
      end else if (pend_be[p]) begin
        wr_mem[ofs] = pend_data[p*8 +: 8];
        wr_set[ofs] = 1'b1;
      end
    end
  endtask

  task automatic step(input bit stim);
    bit done_now;
    @(posedge i_clk);
    drive_inputs(stim);
    @(negedge i_clk);
    done_now = m_inflight && !i_l1d_wr_conflict;
    if (done_now) apply_write();
    check_cycle();
  endtask

  task automatic compare_memories();
    for (int i = 0; i < NUM_BYTES; i++) begin
      if ({st_set[i], st_mem[i]} !== {wr_set[i], wr_mem[i]}) begin
        report_mismatch($sformatf("mem_byte_%0d", i), 128'({st_set[i], st_mem[i]}),
                        128'({wr_set[i], wr_mem[i]}));
      end
    end
  endtask

  initial begin
    int waited;
    i_clk             = 1'b0;
    i_reset_n         = 1'b0;
    i_st_valid        = 1'b0;
    i_st_paddr        = '0;
    i_st_strb         = '0;
    i_st_data         = '0;
    i_l1d_wr_conflict = 1'b0;
    i_fwd_valid       = 1'b0;
    i_fwd_paddr       = '0;
    void'($urandom(32'hf08c_06a8));
    for (int i = 0; i < NUM_BYTES; i++) begin
      st_mem[i] = '0;
      wr_mem[i] = '0;
    end

    repeat (2) @(posedge i_clk);
    // Look up a stored line while the entries are held in reset
    i_fwd_valid <= 1'b1;
    i_fwd_paddr <= BASE_ADDR;
    @(negedge i_clk);
    if (o_empty !== 1'b1) report_mismatch("reset_empty", 128'(1), 128'(o_empty));
    if (o_l1d_wr_valid !== 1'b0) report_mismatch("reset_wr_valid", 128'(0), 128'(o_l1d_wr_valid));
    if (o_fwd_hit !== 1'b0) report_mismatch("reset_fwd_hit", 128'(0), 128'(o_fwd_hit));
    @(posedge i_clk);
    i_reset_n   <= 1'b1;
    i_fwd_valid <= 1'b0;

    for (int c = 0; c < STIM_CYCLES; c++) begin
      step(1'b1);
    end

    // Drain with stimulus off
    waited = 0;
    while (o_empty !== 1'b1 && waited < DRAIN_LIMIT) begin
      step(1'b0);
      waited++;
    end
    if (o_empty !== 1'b1) begin
      $display("Buffer still holds entries after %0d drain cycles", DRAIN_LIMIT);
      n_errors++;
    end
    if (o_l1d_wr_valid !== 1'b0) report_mismatch("drained_wr_valid", 128'(0), 128'(o_l1d_wr_valid));
    compare_memories();

    $display("Stores alloc %0d merge %0d full %0d, writes %0d, conflicts %0d, errors %0d",
             n_alloc, n_merge, n_full, n_writes, n_conflicts, n_errors);
    if (n_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== stbuf.f ====
+incdir+hw
hw/stbuf_pkg.sv
hw/stbuf_alloc.sv
hw/stbuf_entry.sv
hw/stbuf_drain.sv
hw/stbuf_fwd.sv
hw/stbuf_top.sv
bench/stbuf_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the store buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f stbuf.f --top-module stbuf_tb -o stbuf_sim
./obj_dir/stbuf_sim > sim.log 2>&1
cat sim.log

if grep -q "=== PASS ===" sim.log; then
  exit 0
fi
exit 1
